// ==== hw/offset_adder.sv ====
// Offset alignment and address adder

`include "operand_addressing_params.svh"

`timescale 1ns/1ps
`default_nettype none

module offset_adder (
    input  logic                              clock,
    input  operand_addressing_pkg::addr_word_t addr_in,
    input  operand_addressing_pkg::addr_word_t offset,
    output operand_addressing_pkg::addr_word_t addr_out
);

    // Offset stages from the table output towards the adder
    operand_addressing_pkg::addr_word_t offset_stage [`OFFSET_DELAY];

    // Raw address held for one clock while its offset catches up
    operand_addressing_pkg::addr_word_t raw_addr;

    // Offset delay line
    always_ff @(posedge clock) begin
        offset_stage[0] <= offset;
        for (int i = 1; i < `OFFSET_DELAY; i++) begin
            offset_stage[i] <= offset_stage[i-1];
        end
    end

    always_ff @(posedge clock) begin
        raw_addr <= addr_in;
    end

    // Sum wraps modulo the address word
    always_ff @(posedge clock) begin
        addr_out <= raw_addr + offset_stage[`OFFSET_DELAY-1];
    end

endmodule

`default_nettype wire

// ==== hw/offset_memory.sv ====
// Per-thread offset table

`include "operand_addressing_params.svh"

`timescale 1ns/1ps
`default_nettype none

module offset_memory (
    input  logic                              clock,
    input  logic                              wren,
    input  operand_addressing_pkg::thread_id_t write_thread,
    input  operand_addressing_pkg::addr_word_t write_data,
    input  operand_addressing_pkg::thread_id_t read_thread,
    output operand_addressing_pkg::addr_word_t offset
);

    // One offset word per thread
    operand_addressing_pkg::addr_word_t table_mem [`THREAD_COUNT];

    // All threads start with no offset
    initial begin
        for (int i = 0; i < `THREAD_COUNT; i++) begin
            table_mem[i] = '0;
        end
    end

    // A read in the same clock as a write to the same entry returns the old word
    // so the small table fits distributed RAM
    always_ff @(posedge clock) begin
        if (wren) begin
            table_mem[write_thread] <= write_data;
        end
        offset <= table_mem[read_thread];
    end

endmodule

`default_nettype wire

// ==== hw/operand_addressing.sv ====
// Per-thread operand addressing unit

`include "operand_addressing_params.svh"

`timescale 1ns/1ps
`default_nettype none

module operand_addressing (
    input  logic                              clock,
    input  logic                              reset,
    input  logic                              wren_a,
    input  logic                              wren_b,
    input  operand_addressing_pkg::addr_word_t write_data,
    input  operand_addressing_pkg::addr_word_t addr_a,
    input  operand_addressing_pkg::addr_word_t addr_b,
    output operand_addressing_pkg::addr_word_t addr_out_a,
    output operand_addressing_pkg::addr_word_t addr_out_b
);

    // Thread numbers shared by both lanes
    operand_addressing_pkg::thread_id_t issue_thread;
    operand_addressing_pkg::thread_id_t lookup_thread;

    // Table outputs, one per lane
    operand_addressing_pkg::addr_word_t offset_a;
    operand_addressing_pkg::addr_word_t offset_b;

    thread_sequencer i_sequencer (
        .clock         (clock),
        .reset         (reset),
        .issue_thread  (issue_thread),
        .lookup_thread (lookup_thread)
    );

    // Lane A
    // Writes land in the issuing thread's entry while reads run ahead

    offset_memory i_memory_a (
        .clock        (clock),
        .wren         (wren_a),
        .write_thread (issue_thread),
        .write_data   (write_data),
        .read_thread  (lookup_thread),
        .offset       (offset_a)
    );

    offset_adder i_adder_a (
        .clock    (clock),
        .addr_in  (addr_a),
        .offset   (offset_a),
        .addr_out (addr_out_a)
    );

    // Lane B
    // Same structure as lane A with its own strobe and table

    offset_memory i_memory_b (
        .clock        (clock),
        .wren         (wren_b),
        .write_thread (issue_thread),
        .write_data   (write_data),
        .read_thread  (lookup_thread),
        .offset       (offset_b)
    );

    offset_adder i_adder_b (
        .clock    (clock),
        .addr_in  (addr_b),
        .offset   (offset_b),
        .addr_out (addr_out_b)
    );

endmodule

`default_nettype wire

// ==== hw/operand_addressing_params.svh ====
// Operand addressing parameters

`ifndef OPERAND_ADDRESSING_PARAMS_SVH
`define OPERAND_ADDRESSING_PARAMS_SVH

// Width of an operand address and of a per-thread offset
`define ADDR_WORD_WIDTH 12

// Hardware threads issuing in round robin, and the bits to number them
`define THREAD_COUNT 8
`define THREAD_ID_WIDTH 3

// Lead of the look-ahead thread counter over the issuing thread
// The lookup output is registered once more before it reaches the table
`define LOOKUP_LEAD 3

// Register stages between the table output and the address adder
`define OFFSET_DELAY 2

`endif

// ==== hw/operand_addressing_pkg.sv ====
// Operand addressing types

`include "operand_addressing_params.svh"

`default_nettype none

package operand_addressing_pkg;

    // One operand address or one offset word
    typedef logic [`ADDR_WORD_WIDTH-1:0] addr_word_t;

    // Number of a hardware thread
    typedef logic [`THREAD_ID_WIDTH-1:0] thread_id_t;

endpackage

`default_nettype wire

// ==== hw/thread_sequencer.sv ====
// Round-robin thread sequencer

`include "operand_addressing_params.svh"

`timescale 1ns/1ps
`default_nettype none

module thread_sequencer (
    input  logic                              clock,
    input  logic                              reset,
    output operand_addressing_pkg::thread_id_t issue_thread,
    output operand_addressing_pkg::thread_id_t lookup_thread
);

    // Look-ahead counter, kept LOOKUP_LEAD threads in front of the issue counter
    operand_addressing_pkg::thread_id_t lead_thread;

    // Advance one thread and wrap after the last one
    function automatic operand_addressing_pkg::thread_id_t next_thread(
        input operand_addressing_pkg::thread_id_t current
    );
        if (current == operand_addressing_pkg::thread_id_t'(`THREAD_COUNT - 1)) begin
            return '0;
        end
        return current + 1'b1;
    endfunction

    // Thread whose addresses are on the lanes in this clock
    always_ff @(posedge clock) begin
        if (reset) begin
            issue_thread <= '0;
        end else begin
            issue_thread <= next_thread(issue_thread);
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            lead_thread <= operand_addressing_pkg::thread_id_t'(
                `LOOKUP_LEAD % `THREAD_COUNT);
        end else begin
            lead_thread <= next_thread(lead_thread);
        end
    end

    // The lookup register retimes the look-ahead count by one clock.
    // The table read and the two offset stages then line the offset
    // up with its thread's address at the adder.
    always_ff @(posedge clock) begin
        if (reset) begin
            lookup_thread <= operand_addressing_pkg::thread_id_t'(
                (`LOOKUP_LEAD + `THREAD_COUNT - 1) % `THREAD_COUNT);
        end else begin
            lookup_thread <= lead_thread;
        end
    end

endmodule

`default_nettype wire

// ==== operand_addressing.f ====
+incdir+hw
hw/operand_addressing_pkg.sv
hw/thread_sequencer.sv
hw/offset_memory.sv
hw/offset_adder.sv
hw/operand_addressing.sv
verif/operand_addressing_assertions.sv
verif/operand_addressing_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the operand addressing testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f operand_addressing.f \
    --top-module operand_addressing_tb \
    -o operand_addressing_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

sim_output=$(./obj_dir/operand_addressing_sim 2>&1)
sim_status=$?
printf '%s\n' "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_output" | grep -qx "Testbench passed"; then
    exit 0
fi

echo "Simulation finished without the pass message"
exit 1

// ==== verif/operand_addressing_assertions.sv ====
// Operand addressing assertions

`include "operand_addressing_params.svh"

`timescale 1ns/1ps
`default_nettype none

module operand_addressing_assertions (
    input  logic                              clock,
    input  logic                              reset,
    input  operand_addressing_pkg::thread_id_t issue_thread,
    input  operand_addressing_pkg::thread_id_t lookup_thread,
    input  operand_addressing_pkg::addr_word_t addr_out_a,
    input  operand_addressing_pkg::addr_word_t addr_out_b
);

    // Counts clocks out of reset and stops once the outputs carry real data
    int clocks_out_of_reset;

    function automatic int wrap_thread(input int value);
        return value % `THREAD_COUNT;
    endfunction

    always_ff @(posedge clock) begin
        if (reset) begin
            clocks_out_of_reset <= 0;
        end else if (clocks_out_of_reset < 2) begin
            clocks_out_of_reset <= clocks_out_of_reset + 1;
        end
    end

    // One thread per clock in strict round robin
    issue_advances: assert property (
        @(posedge clock) disable iff (reset)
        !$past(reset) |-> int'(issue_thread) == wrap_thread(int'($past(issue_thread)) + 1)
    ) else $error("issue thread did not advance by one thread");

    // The look-ahead count passes one retiming register on its way to the tables
    lookup_leads: assert property (
        @(posedge clock) disable iff (reset)
        int'(lookup_thread) == wrap_thread(int'(issue_thread) + `LOOKUP_LEAD - 1)
    ) else $error("lookup thread is out of step with the issue thread");

    // The first two clocks out of reset still drain unreset datapath registers
    outputs_known: assert property (
        @(posedge clock) disable iff (reset)
        clocks_out_of_reset >= 2 |-> !$isunknown(addr_out_a) && !$isunknown(addr_out_b)
    ) else $error("address outputs are unknown after the pipeline filled");

endmodule

bind operand_addressing operand_addressing_assertions i_assertions (
    .clock         (clock),
    .reset         (reset),
    .issue_thread  (issue_thread),
    .lookup_thread (lookup_thread),
    .addr_out_a    (addr_out_a),
    .addr_out_b    (addr_out_b)
);

`default_nettype wire

// ==== verif/operand_addressing_tb.sv ====
// Operand addressing testbench

`include "operand_addressing_params.svh"

`timescale 1ns/1ps
`default_nettype none

module operand_addressing_tb;

    localparam int ROW_COUNT = 48;
    localparam int FIELD_COUNT = 8;
    localparam int RESET_CYCLES = 5;
    localparam int PIPELINE_LATENCY = 2;
    localparam int DRAIN_LIMIT = 10;

    // Columns of one test data row
    localparam int COL_WREN_A = 0;
    localparam int COL_WREN_B = 1;
    localparam int COL_WRITE_DATA = 2;
    localparam int COL_ADDR_A = 3;
    localparam int COL_ADDR_B = 4;
    localparam int COL_EXPECT_A = 5;
    localparam int COL_EXPECT_B = 6;
    localparam int COL_CHECK = 7;

    logic clock;
    logic reset;
    logic wren_a;
    logic wren_b;
    operand_addressing_pkg::addr_word_t write_data;
    operand_addressing_pkg::addr_word_t addr_a;
    operand_addressing_pkg::addr_word_t addr_b;
    operand_addressing_pkg::addr_word_t addr_out_a;
    operand_addressing_pkg::addr_word_t addr_out_b;

    operand_addressing_pkg::addr_word_t testdata [ROW_COUNT*FIELD_COUNT];

    // Rows driven but not yet compared, oldest first
    int pending_rows [$];

    // Falling edges since reset released
    int cycle;

    int check_count;
    int mismatch_count;
    int other_error_count;
    int drain_cycles;

    operand_addressing i_dut (
        .clock      (clock),
        .reset      (reset),
        .wren_a     (wren_a),
        .wren_b     (wren_b),
        .write_data (write_data),
        .addr_a     (addr_a),
        .addr_b     (addr_b),
        .addr_out_a (addr_out_a),
        .addr_out_b (addr_out_b)
    );

    always #20 clock = ~clock;

    function automatic operand_addressing_pkg::addr_word_t word_field(
        input int row,
        input int column
    );
        return testdata[row*FIELD_COUNT + column];
    endfunction

    function automatic logic bit_field(input int row, input int column);
        return testdata[row*FIELD_COUNT + column][0];
    endfunction

    task automatic check_equal(
        input string                              test_name,
        input operand_addressing_pkg::addr_word_t expected,
        input operand_addressing_pkg::addr_word_t actual
    );
        check_count++;
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %03h, actual %03h", test_name, expected, actual);
            mismatch_count++;
        end
    endtask

    task automatic drive_row(input int row);
        wren_a = bit_field(row, COL_WREN_A);
        wren_b = bit_field(row, COL_WREN_B);
        write_data = word_field(row, COL_WRITE_DATA);
        addr_a = word_field(row, COL_ADDR_A);
        addr_b = word_field(row, COL_ADDR_B);
    endtask

    task automatic drive_idle();
        wren_a = 1'b0;
        wren_b = 1'b0;
        write_data = '0;
        addr_a = '0;
        addr_b = '0;
    endtask

    // Compare every row whose result has had two rising edges to come out
    task automatic check_due_rows();
        int row;
        while (pending_rows.size() > 0 && pending_rows[0] + PIPELINE_LATENCY <= cycle) begin
            row = pending_rows.pop_front();
            if (bit_field(row, COL_CHECK)) begin
                check_equal($sformatf("row %0d lane A", row),
                            word_field(row, COL_EXPECT_A), addr_out_a);
                check_equal($sformatf("row %0d lane B", row),
                            word_field(row, COL_EXPECT_B), addr_out_b);
            end
        end
    endtask

    // Reset is released on a falling edge, which becomes cycle 0
    task automatic apply_reset();
        int held;
        reset = 1'b1;
        held = 0;
        while (held < RESET_CYCLES) begin
            @(posedge clock);
            held++;
        end
        @(negedge clock);
        reset = 1'b0;
        cycle = 0;
    endtask

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        drive_idle();
        cycle = 0;
        check_count = 0;
        mismatch_count = 0;
        other_error_count = 0;
        drain_cycles = 0;

        $readmemh("verif/operand_addressing_testdata.hex", testdata);

        apply_reset();

        // Row i goes in on the falling edge of clock i, so its thread is i mod 8
        for (int row = 0; row < ROW_COUNT; row++) begin
            check_due_rows();
            drive_row(row);
            pending_rows.push_back(row);
            @(negedge clock);
            cycle++;
        end

        drive_idle();
        check_due_rows();
        while (pending_rows.size() > 0 && drain_cycles < DRAIN_LIMIT) begin
            @(negedge clock);
            cycle++;
            drain_cycles++;
            check_due_rows();
        end
        if (pending_rows.size() > 0) begin
            $display("Timeout: %0d rows were never compared after %0d drain clocks",
                     pending_rows.size(), drain_cycles);
            other_error_count++;
        end

        if (check_count == 0) begin
            $display("No output was compared because the test data has no checked rows");
            other_error_count++;
        end

        $display("Summary: %0d checks, %0d mismatches, %0d other errors",
                 check_count, mismatch_count, other_error_count);
        if (mismatch_count == 0 && other_error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/operand_addressing_testdata.hex ====
// wren_a wren_b write_data addr_a addr_b expect_out_a expect_out_b check
// One row per clock after reset, thread is row mod 8, outputs due two clocks later
// Round 0 with zero offsets while lane A offsets are written
1 0 110 200 300 200 300 0
1 0 220 201 301 201 301 0
1 0 330 202 302 202 302 1
1 0 440 203 303 203 303 1
1 0 550 204 304 204 304 1
1 0 660 205 305 205 305 1
1 0 770 206 306 206 306 1
1 0 880 207 307 207 307 1
// Round 1 with one address for all threads and lane B writes on even threads
0 1 00F 400 400 510 400 1
0 0 000 400 400 620 400 1
0 1 0F0 400 400 730 400 1
0 0 000 400 400 840 400 1
0 1 F00 400 400 950 400 1
0 0 000 400 400 A60 400 1
0 1 123 400 400 B70 400 1
0 0 000 400 400 C80 400 1
// Round 2 where lane B offsets apply and threads 1 and 3 are rewritten
0 0 000 100 200 210 20F 1
1 0 7FF 101 201 321 201 1
0 0 000 102 202 432 2F2 1
1 1 005 103 203 543 203 1
0 0 000 104 204 654 104 1
0 0 000 105 205 765 205 1
0 0 000 106 206 876 329 1
0 0 000 107 207 987 207 1
// Round 3 near the top of the address space and thread 1 overwritten again
0 0 000 FF0 FFF 100 00E 1
1 0 001 FF1 FFE 7F0 FFE 1
0 0 000 FF2 FFD 322 0ED 1
0 0 000 FF3 FFC FF8 001 1
0 0 000 FF4 FFB 544 EFB 1
0 0 000 FF5 FFA 655 FFA 1
0 0 000 FF6 FF9 766 11C 1
0 0 000 FF7 FF8 877 FF8 1
// Round 4 with mixed addresses and late writes on threads 5 and 7
0 0 000 123 456 233 465 1
0 0 000 ABC DEF ABD DEF 1
0 0 000 5A5 A5A 8D5 B4A 1
0 0 000 000 000 005 005 1
0 0 000 7FF 0FF D4F FFF 1
0 1 800 246 8AC 8A6 8AC 1
0 0 000 E01 1E0 571 303 1
1 1 FFF 321 654 BA1 654 1
// Round 5 with every offset in place
0 0 000 FFF 001 10F 010 1
0 0 000 800 800 801 800 1
0 0 000 C00 F20 F30 010 1
0 0 000 FFB FFA 000 FFF 1
0 0 000 0AB 1CD 5FB 0CD 1
0 0 000 3C3 900 A23 100 1
0 0 000 89A EDC 00A FFF 1
0 0 000 002 003 001 002 1
